// File: common/i2cPkg.sv
package i2cPkg;

  // ******************************
  // Widths
  // ******************************
  localparam int ByteWidth  = 8;
  localparam int WordWidth  = 16;
  localparam int AddrWidth  = 3;
  localparam int FrameWidth = 9;
  localparam int BitIdxWidth = 4;

  // Register and data values
  typedef logic [ByteWidth-1:0]   byteT;
  typedef logic [WordWidth-1:0]   wordT;
  typedef logic [AddrWidth-1:0]   regAddrT;
  typedef logic [1:0]             accessT;

  // Ack in bit 8, data byte in bits 7:0
  typedef logic [FrameWidth-1:0]  frameT;
  typedef logic [BitIdxWidth-1:0] bitIdxT;

  // Index of the acknowledge bit in a frame
  localparam bitIdxT LastBitIdx = 4'd8;

  // ******************************
  // Bus access sizes
  // ******************************
  localparam accessT AccNone = 2'b00;
  localparam accessT AccByte = 2'b01;
  localparam accessT AccWord = 2'b11;

  // ******************************
  // Register map
  // ******************************
  // Ctrl  W: WrRd[7] Stop[1] Start[0]  R: Busy[7] TOutNZ[6]
  localparam regAddrT AddrCtrl = 3'd0;
  localparam regAddrT AddrBaud = 3'd1;
  // Word access, ack in bit 8
  localparam regAddrT AddrData = 3'd2;
  localparam regAddrT AddrGpio = 3'd3;
  localparam regAddrT AddrPres = 3'd4;
  // Word read restarts the timeout
  localparam regAddrT AddrTOut = 3'd5;

  // ******************************
  // Sequencer states
  // ******************************
  typedef enum logic [3:0]
  {
    Idle,
    StartA,
    StartB,
    StartC,
    StartD,
    DataA,
    DataB,
    DataC,
    DataD,
    DataE,
    StopA,
    StopB,
    StopC
  } i2cStateT;

endpackage

// File: i2cBitFsm/i2cBitFsm.sv
`timescale 1ns/1ns

module i2cBitFsm
(
  input  logic          AClkH,
  input  logic          AResetB,
  input  logic          sendStart,
  input  logic          sendStop,
  input  logic          sendData,
  input  i2cPkg::frameT dataSend,
  input  i2cPkg::byteT  baud,
  input  logic          wrRd,
  output logic          busy,
  output i2cPkg::frameT dataRecv,
  input  logic          SdaI,
  output logic          SdaO,
  output logic          Scl
);

  i2cPkg::i2cStateT state;
  i2cPkg::i2cStateT stateNxt;
  i2cPkg::byteT     baudDiv;
  i2cPkg::byteT     baudDivNxt;
  i2cPkg::bitIdxT   bitIdx;
  i2cPkg::bitIdxT   bitIdxNxt;
  i2cPkg::frameT    shiftO;
  i2cPkg::frameT    shiftONxt;
  i2cPkg::frameT    shiftI;
  i2cPkg::frameT    shiftINxt;

  logic sdaMeta;
  logic sdaSync;
  logic sdaReg;
  logic sdaNxt;
  logic sclReg;
  logic sclNxt;
  logic baudEnd;
  logic lastBit;
  logic lastBitNxt;
  logic enter;
  logic txBit;

  assign baudEnd = (baudDiv == '0);
  assign lastBit = (bitIdx == i2cPkg::LastBitIdx);

  // ******************************
  // Next state
  // ******************************
  always_comb
  begin
    stateNxt = state;
    case (state)
      i2cPkg::Idle:
      begin
        // Only one request is taken, start first
        if (sendStart)
          stateNxt = i2cPkg::StartA;
        else if (sendData)
          stateNxt = i2cPkg::DataA;
        else if (sendStop)
          stateNxt = i2cPkg::StopA;
      end
      i2cPkg::StartA: if (baudEnd) stateNxt = i2cPkg::StartB;
      i2cPkg::StartB: if (baudEnd) stateNxt = i2cPkg::StartC;
      i2cPkg::StartC: if (baudEnd) stateNxt = i2cPkg::StartD;
      i2cPkg::StartD: if (baudEnd) stateNxt = i2cPkg::Idle;
      // Single cycle, divider not loaded
      i2cPkg::DataA:  stateNxt = i2cPkg::DataB;
      i2cPkg::DataB:  if (baudEnd) stateNxt = i2cPkg::DataC;
      i2cPkg::DataC:  if (baudEnd) stateNxt = i2cPkg::DataD;
      i2cPkg::DataD:  if (baudEnd) stateNxt = i2cPkg::DataE;
      i2cPkg::DataE:
      begin
        if (baudEnd)
          stateNxt = lastBit ? i2cPkg::Idle : i2cPkg::DataB;
      end
      i2cPkg::StopA:  if (baudEnd) stateNxt = i2cPkg::StopB;
      i2cPkg::StopB:  if (baudEnd) stateNxt = i2cPkg::StopC;
      i2cPkg::StopC:  if (baudEnd) stateNxt = i2cPkg::Idle;
      default:        stateNxt = i2cPkg::Idle;
    endcase
  end

  // Divider reload on entry to any timed phase
  assign enter = (stateNxt != state) && (stateNxt != i2cPkg::Idle)
                 && (stateNxt != i2cPkg::DataA);

  // ******************************
  // Datapath
  // ******************************
  always_comb
  begin
    baudDivNxt = enter ? baud : baudDiv - {7'h00, !baudEnd};

    bitIdxNxt = bitIdx;
    if (state == i2cPkg::DataA)
      bitIdxNxt = '0;
    else if ((state == i2cPkg::DataE) && baudEnd && !lastBit)
      bitIdxNxt = bitIdx + 4'd1;

    // MSB first, ack last
    shiftONxt = shiftO;
    if ((state == i2cPkg::Idle) && !sendStart && sendData)
      shiftONxt = {dataSend[7:0], dataSend[8]};
    else if ((state == i2cPkg::DataE) && baudEnd)
      shiftONxt = {shiftO[7:0], 1'b1};

    // Sample at the end of SCL high
    shiftINxt = shiftI;
    if ((state == i2cPkg::DataD) && baudEnd)
      shiftINxt = {shiftI[7:0], sdaSync};
  end

  // Write drives data and releases ack, read the reverse
  assign lastBitNxt = (bitIdxNxt == i2cPkg::LastBitIdx);
  assign txBit = wrRd ? (lastBitNxt ? 1'b1 : shiftONxt[8])
                      : (lastBitNxt ? shiftONxt[8] : 1'b1);

  // ******************************
  // Line levels per state
  // ******************************
  always_comb
  begin
    sclNxt = sclReg;
    sdaNxt = sdaReg;
    case (stateNxt)
      // Release SDA first in case of repeated start
      i2cPkg::StartA: sdaNxt = 1'b1;
      i2cPkg::StartB: {sclNxt, sdaNxt} = 2'b11;
      i2cPkg::StartC: {sclNxt, sdaNxt} = 2'b10;
      i2cPkg::StartD: {sclNxt, sdaNxt} = 2'b00;
      i2cPkg::DataA:  sclNxt = 1'b0;
      // SDA only changes while SCL is low
      i2cPkg::DataB:  {sclNxt, sdaNxt} = {1'b0, txBit};
      i2cPkg::DataC:  sclNxt = 1'b1;
      i2cPkg::DataD:  sclNxt = 1'b1;
      i2cPkg::DataE:  sclNxt = 1'b0;
      i2cPkg::StopA:  {sclNxt, sdaNxt} = 2'b00;
      i2cPkg::StopB:  {sclNxt, sdaNxt} = 2'b10;
      i2cPkg::StopC:  {sclNxt, sdaNxt} = 2'b11;
      default:        ;
    endcase
  end

  // ******************************
  // Registers
  // ******************************
  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      state   <= i2cPkg::Idle;
      baudDiv <= '0;
      bitIdx  <= '0;
      shiftI  <= '0;
      sdaMeta <= 1'b1;
      sdaSync <= 1'b1;
      sdaReg  <= 1'b1;
      sclReg  <= 1'b1;
    end
    else
    begin
      state   <= stateNxt;
      baudDiv <= baudDivNxt;
      bitIdx  <= bitIdxNxt;
      shiftI  <= shiftINxt;
      sdaMeta <= SdaI;
      sdaSync <= sdaMeta;
      sdaReg  <= sdaNxt;
      sclReg  <= sclNxt;
    end
  end

  always_ff @(posedge AClkH)
  begin
    shiftO <= shiftONxt;
  end

  assign busy     = (state != i2cPkg::Idle);
  assign dataRecv = {shiftI[0], shiftI[8:1]};
  assign SdaO     = sdaReg;
  assign Scl      = sclReg;

endmodule

// File: hdl/i2cRegFile.sv
`timescale 1ns/1ns

module i2cRegFile #(parameter int GpioWidth = 4)
(
  input  logic                 AClkH,
  input  logic                 AResetB,
  input  i2cPkg::regAddrT      Addr,
  input  i2cPkg::wordT         Mosi,
  input  i2cPkg::accessT       WrEn,
  input  i2cPkg::accessT       RdEn,
  output i2cPkg::wordT         Miso,
  input  logic [GpioWidth-1:0] GpioI,
  output logic                 sendStart,
  output logic                 sendStop,
  output logic                 sendData,
  output i2cPkg::frameT        dataSend,
  output i2cPkg::byteT         baud,
  output logic                 wrRd,
  input  logic                 busy,
  input  i2cPkg::frameT        dataRecv,
  output logic                 presWr,
  output logic                 toutWr,
  output logic                 toutRestart,
  output i2cPkg::wordT         cfgData,
  input  logic                 timerNZ
);

  logic wrByte;
  logic wrWord;
  logic rdByte;
  logic rdWord;
  logic ctrlWr;

  i2cPkg::byteT         baudReg;
  logic                 wrRdReg;
  logic [GpioWidth-1:0] gpioMeta;
  logic [GpioWidth-1:0] gpioSync;

  // ******************************
  // Access decode
  // ******************************
  assign wrByte = (WrEn == i2cPkg::AccByte);
  assign wrWord = (WrEn == i2cPkg::AccWord);
  assign rdByte = (RdEn == i2cPkg::AccByte);
  assign rdWord = (RdEn == i2cPkg::AccWord);
  assign ctrlWr = wrByte && (Addr == i2cPkg::AddrCtrl);

  // Request pulses to the sequencer
  assign sendStart = ctrlWr && Mosi[0];
  assign sendStop  = ctrlWr && Mosi[1];
  assign sendData  = wrWord && (Addr == i2cPkg::AddrData);
  assign dataSend  = Mosi[8:0];

  // Timeout configuration
  assign presWr      = wrWord && (Addr == i2cPkg::AddrPres);
  assign toutWr      = wrWord && (Addr == i2cPkg::AddrTOut);
  assign toutRestart = rdWord && (Addr == i2cPkg::AddrTOut);
  assign cfgData     = Mosi;

  // ******************************
  // Registers
  // ******************************
  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      baudReg  <= '0;
      wrRdReg  <= 1'b0;
      gpioMeta <= '0;
      gpioSync <= '0;
    end
    else
    begin
      if (ctrlWr)
        wrRdReg <= Mosi[7];
      if (wrByte && (Addr == i2cPkg::AddrBaud))
        baudReg <= Mosi[7:0];
      // Two stage input synchronizer
      gpioMeta <= GpioI;
      gpioSync <= gpioMeta;
    end
  end

  assign baud = baudReg;
  assign wrRd = wrRdReg;

  // ******************************
  // Read mux
  // ******************************
  always_comb
  begin
    Miso = '0;
    if (rdByte)
    begin
      case (Addr)
        i2cPkg::AddrCtrl: Miso = {8'h00, busy, timerNZ, 6'h00};
        i2cPkg::AddrBaud: Miso = {8'h00, baudReg};
        i2cPkg::AddrGpio: Miso = i2cPkg::wordT'(gpioSync);
        default:          Miso = '0;
      endcase
    end
    else if (rdWord && (Addr == i2cPkg::AddrData))
    begin
      // Ack in bit 8
      Miso = {7'h00, dataRecv};
    end
  end

endmodule

// File: hdl/i2cTimeout.sv
`timescale 1ns/1ns

module i2cTimeout #(parameter int TimerWidth = 16)
(
  input  logic         AClkH,
  input  logic         AResetB,
  input  logic         presWr,
  input  logic         toutWr,
  input  logic         toutRestart,
  input  i2cPkg::wordT cfgData,
  output logic         timerNZ
);

  logic [TimerWidth-1:0] presCfg;
  logic [TimerWidth-1:0] toutCfg;
  logic [TimerWidth-1:0] pres;
  logic [TimerWidth-1:0] tout;
  logic                  presNZ;
  logic                  toutNZ;

  assign presNZ = (pres != '0);
  assign toutNZ = (tout != '0);

  // ******************************
  // Prescaled down-counter
  // ******************************
  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      presCfg <= '0;
      toutCfg <= '0;
      pres    <= '0;
      tout    <= '0;
    end
    else
    begin
      if (presWr)
        presCfg <= cfgData[TimerWidth-1:0];
      if (toutWr)
        toutCfg <= cfgData[TimerWidth-1:0];

      if (toutRestart)
      begin
        // Zero count keeps the prescaler idle too
        tout <= toutCfg;
        pres <= (toutCfg != '0) ? presCfg : '0;
      end
      else if (presNZ)
        pres <= pres - 1'b1;
      else if (toutNZ)
      begin
        tout <= tout - 1'b1;
        // No reload on the final tick
        pres <= (tout != TimerWidth'(1)) ? presCfg : '0;
      end
    end
  end

  assign timerNZ = presNZ || toutNZ;

endmodule

// File: hdl/i2cMaster.sv
`timescale 1ns/1ns

module i2cMaster #(
  parameter int GpioWidth  = 4,
  parameter int TimerWidth = 16
)
(
  input  logic                 AClkH,
  input  logic                 AResetB,
  input  i2cPkg::regAddrT      Addr,
  input  i2cPkg::wordT         Mosi,
  input  i2cPkg::accessT       WrEn,
  input  i2cPkg::accessT       RdEn,
  output i2cPkg::wordT         Miso,
  input  logic                 SdaI,
  output logic                 SdaO,
  output logic                 Scl,
  input  logic [GpioWidth-1:0] GpioI
);

  // Register file to sequencer
  logic          sendStart;
  logic          sendStop;
  logic          sendData;
  i2cPkg::frameT dataSend;
  i2cPkg::byteT  baud;
  logic          wrRd;
  logic          busy;
  i2cPkg::frameT dataRecv;

  // Register file to timeout
  logic          presWr;
  logic          toutWr;
  logic          toutRestart;
  i2cPkg::wordT  cfgData;
  logic          timerNZ;

  i2cRegFile #(.GpioWidth(GpioWidth)) i_i2cRegFile
  (
    .AClkH       (AClkH),
    .AResetB     (AResetB),
    .Addr        (Addr),
    .Mosi        (Mosi),
    .WrEn        (WrEn),
    .RdEn        (RdEn),
    .Miso        (Miso),
    .GpioI       (GpioI),
    .sendStart   (sendStart),
    .sendStop    (sendStop),
    .sendData    (sendData),
    .dataSend    (dataSend),
    .baud        (baud),
    .wrRd        (wrRd),
    .busy        (busy),
    .dataRecv    (dataRecv),
    .presWr      (presWr),
    .toutWr      (toutWr),
    .toutRestart (toutRestart),
    .cfgData     (cfgData),
    .timerNZ     (timerNZ)
  );

  i2cBitFsm i_i2cBitFsm
  (
    .AClkH     (AClkH),
    .AResetB   (AResetB),
    .sendStart (sendStart),
    .sendStop  (sendStop),
    .sendData  (sendData),
    .dataSend  (dataSend),
    .baud      (baud),
    .wrRd      (wrRd),
    .busy      (busy),
    .dataRecv  (dataRecv),
    .SdaI      (SdaI),
    .SdaO      (SdaO),
    .Scl       (Scl)
  );

  i2cTimeout #(.TimerWidth(TimerWidth)) i_i2cTimeout
  (
    .AClkH       (AClkH),
    .AResetB     (AResetB),
    .presWr      (presWr),
    .toutWr      (toutWr),
    .toutRestart (toutRestart),
    .cfgData     (cfgData),
    .timerNZ     (timerNZ)
  );

endmodule

// File: sim/i2cBitFsm_checker.sv
`timescale 1ns/1ns

module i2cBitFsmChecker
(
  input logic             AClkH,
  input logic             AResetB,
  input i2cPkg::i2cStateT state,
  input i2cPkg::bitIdxT   bitIdx,
  input logic             sendStart,
  input logic             sendStop,
  input logic             sendData,
  input logic             busy,
  input logic             SdaO,
  input logic             Scl
);

  int   failCount = 0;
  logic startStop;
  logic request;

  // Start and stop phases may move SDA with SCL high
  assign startStop = ((state >= i2cPkg::StartA) && (state <= i2cPkg::StartD))
                     || ((state >= i2cPkg::StopA) && (state <= i2cPkg::StopC));

  assign request = sendStart || sendStop || sendData;

  // ******************************
  // Line protocol
  // ******************************
  assert property (@(posedge AClkH) disable iff (!AResetB)
                   (Scl && $past(Scl) && !startStop) |-> $stable(SdaO))
  else
  begin
    $error("SDA changed while SCL was high in a data phase");
    failCount++;
  end

  // ******************************
  // Sequencer state
  // ******************************
  // From idle, busy rises exactly one cycle after a request
  assert property (@(posedge AClkH) disable iff (!AResetB)
                   !busy |=> (busy == $past(request)))
  else
  begin
    $error("Busy did not follow a request from idle");
    failCount++;
  end

  assert property (@(posedge AClkH) disable iff (!AResetB)
                   bitIdx <= i2cPkg::LastBitIdx)
  else
  begin
    $error("Bit counter ran past the acknowledge bit");
    failCount++;
  end

endmodule

bind i2cBitFsm i2cBitFsmChecker i_i2cBitFsmChecker
(
  .AClkH     (AClkH),
  .AResetB   (AResetB),
  .state     (state),
  .bitIdx    (bitIdx),
  .sendStart (sendStart),
  .sendStop  (sendStop),
  .sendData  (sendData),
  .busy      (busy),
  .SdaO      (SdaO),
  .Scl       (Scl)
);

// File: sim/i2cMasterTb.sv
`timescale 1ns/1ns

module i2cMasterTb;

  localparam int           GpioWidth = 4;
  localparam int           PollLimit = 4000;
  localparam logic [15:0]  LfsrSeed  = 16'd56057;
  localparam logic [15:0]  LfsrTaps  = 16'hB400;

  logic                 AClkH;
  logic                 AResetB;
  i2cPkg::regAddrT      Addr;
  i2cPkg::wordT         Mosi;
  i2cPkg::accessT       WrEn;
  i2cPkg::accessT       RdEn;
  i2cPkg::wordT         Miso;
  logic                 SdaI;
  logic                 SdaO;
  logic                 Scl;
  logic [GpioWidth-1:0] GpioI;

  logic [15:0]   lfsrState;
  i2cPkg::frameT slaveTx;
  i2cPkg::frameT slaveRx;
  int            slaveIdx;
  int            rxCount;
  int            startCount;
  int            expStarts;
  logic          slaveSda;
  i2cPkg::wordT  rdData;
  i2cPkg::byteT  baudVal;
  i2cPkg::byteT  dataVal;
  logic          ackVal;

  i2cMaster i_i2cMaster
  (
    .AClkH   (AClkH),
    .AResetB (AResetB),
    .Addr    (Addr),
    .Mosi    (Mosi),
    .WrEn    (WrEn),
    .RdEn    (RdEn),
    .Miso    (Miso),
    .SdaI    (SdaI),
    .SdaO    (SdaO),
    .Scl     (Scl),
    .GpioI   (GpioI)
  );

  initial
  begin
    AClkH = 1'b0;
    forever
    begin
      #5;
      AClkH = ~AClkH;
    end
  end

  // ******************************
  // Open-drain slave
  // ******************************
  assign slaveSda = (slaveIdx < 9) ? slaveTx[8 - slaveIdx] : 1'b1;
  assign SdaI     = SdaO & slaveSda;

  // Next bit goes out while SCL is low
  always @(negedge Scl)
  begin
    if (slaveIdx < 9)
      slaveIdx++;
  end

  always @(posedge Scl)
  begin
    slaveRx = {slaveRx[7:0], SdaI};
    rxCount++;
  end

  // START, SDA falls with SCL high
  always @(negedge SdaI)
  begin
    if (Scl)
      startCount++;
  end

  // ******************************
  // Random numbers
  // ******************************
  function automatic logic stepLfsr();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit)
      lfsrState = lfsrState ^ LfsrTaps;
    return outBit;
  endfunction

  function automatic i2cPkg::wordT nextBits(input int count);
    i2cPkg::wordT bits;
    int           i;
    bits = '0;
    for (i = 0; i < count; i++)
      bits = {bits[14:0], stepLfsr()};
    return bits;
  endfunction

  // ******************************
  // Failure and compare tasks
  // ******************************
  task automatic abortRun;
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic checkByte(input string what, input i2cPkg::byteT got,
                           input i2cPkg::byteT exp);
    if (got !== exp)
    begin
      $display("ERR %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
      abortRun();
    end
  endtask

  task automatic checkFrame(input string what, input i2cPkg::frameT got,
                            input i2cPkg::frameT exp);
    if (got !== exp)
    begin
      $display("ERR %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
      abortRun();
    end
  endtask

  task automatic checkWord(input string what, input i2cPkg::wordT got,
                           input i2cPkg::wordT exp);
    if (got !== exp)
    begin
      $display("ERR %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
      abortRun();
    end
  endtask

  // ******************************
  // Bus access
  // ******************************
  task automatic stepClock;
    @(posedge AClkH);
    #1;
  endtask

  task automatic busWrite(input i2cPkg::regAddrT addr, input i2cPkg::wordT data,
                          input i2cPkg::accessT size);
    Addr = addr;
    Mosi = data;
    WrEn = size;
    stepClock();
    WrEn = i2cPkg::AccNone;
  endtask

  // Miso is combinational, sampled mid-cycle
  task automatic busRead(input i2cPkg::regAddrT addr, input i2cPkg::accessT size,
                         output i2cPkg::wordT data);
    Addr = addr;
    RdEn = size;
    #4;
    data = Miso;
    stepClock();
    RdEn = i2cPkg::AccNone;
  endtask

  task automatic waitIdle;
    i2cPkg::wordT status;
    int           polls;
    polls = 0;
    busRead(i2cPkg::AddrCtrl, i2cPkg::AccByte, status);
    while (status[7])
    begin
      polls++;
      if (polls > PollLimit)
      begin
        $display("Timeout: the sequencer stayed busy for %0d status reads", PollLimit);
        abortRun();
      end
      busRead(i2cPkg::AddrCtrl, i2cPkg::AccByte, status);
    end
  endtask

  // ******************************
  // I2C operations
  // ******************************
  task automatic issueStart(input logic wrRdBit);
    busWrite(i2cPkg::AddrCtrl, {8'h00, wrRdBit, 6'h00, 1'b1}, i2cPkg::AccByte);
    waitIdle();
    expStarts++;
    checkByte("start count", i2cPkg::byteT'(startCount), i2cPkg::byteT'(expStarts));
  endtask

  task automatic issueStop;
    busWrite(i2cPkg::AddrCtrl, 16'h0002, i2cPkg::AccByte);
    waitIdle();
  endtask

  // Slave bits in time order, first bit in bit 8
  task automatic runFrame(input i2cPkg::frameT frame, input i2cPkg::frameT slaveBits,
                          input logic wrRdBit, input logic pokeStart);
    slaveTx  = slaveBits;
    slaveRx  = '0;
    rxCount  = 0;
    slaveIdx = 0;
    busWrite(i2cPkg::AddrData, {7'h00, frame}, i2cPkg::AccWord);
    if (pokeStart)
      busWrite(i2cPkg::AddrCtrl, {8'h00, wrRdBit, 6'h00, 1'b1}, i2cPkg::AccByte);
    waitIdle();
    checkByte("slave clock count", i2cPkg::byteT'(rxCount), 8'd9);
  endtask

  task automatic runTimeout(input i2cPkg::wordT pres, input i2cPkg::wordT count);
    i2cPkg::wordT status;
    int           limit;
    int           cycles;
    limit = int'(count) * (int'(pres) + 1) + 4;
    busWrite(i2cPkg::AddrPres, pres, i2cPkg::AccWord);
    busWrite(i2cPkg::AddrTOut, count, i2cPkg::AccWord);
    busRead(i2cPkg::AddrTOut, i2cPkg::AccWord, status);
    busRead(i2cPkg::AddrCtrl, i2cPkg::AccByte, status);
    checkByte("timeout status", status[7:0], (count != '0) ? 8'h40 : 8'h00);
    cycles = 1;
    while (status[6])
    begin
      if (cycles > limit)
      begin
        $display("Timeout: status bit 6 still set after %0d cycles", limit);
        abortRun();
      end
      busRead(i2cPkg::AddrCtrl, i2cPkg::AccByte, status);
      cycles++;
    end
  endtask

  // ******************************
  // Test sequence
  // ******************************
  initial
  begin
    lfsrState  = LfsrSeed;
    AResetB    = 1'b0;
    Addr       = '0;
    Mosi       = '0;
    WrEn       = i2cPkg::AccNone;
    RdEn       = i2cPkg::AccNone;
    GpioI      = '0;
    slaveTx    = '1;
    slaveRx    = '0;
    slaveIdx   = 9;
    rxCount    = 0;
    startCount = 0;
    expStarts  = 0;
    repeat (16) @(posedge AClkH);
    #1;
    AResetB = 1'b1;
    stepClock();

    // Reset values
    checkByte("line levels", {6'h00, Scl, SdaO}, 8'h03);
    busRead(i2cPkg::AddrCtrl, i2cPkg::AccByte, rdData);
    checkByte("control after reset", rdData[7:0], 8'h00);
    busRead(i2cPkg::AddrBaud, i2cPkg::AccByte, rdData);
    checkByte("baud after reset", rdData[7:0], 8'h00);
    busRead(i2cPkg::AddrData, i2cPkg::AccWord, rdData);
    checkWord("data after reset", rdData, 16'h0000);

    // Baud readback, idle status
    baudVal = i2cPkg::byteT'(nextBits(3));
    busWrite(i2cPkg::AddrBaud, {8'h00, baudVal}, i2cPkg::AccByte);
    busRead(i2cPkg::AddrBaud, i2cPkg::AccByte, rdData);
    checkByte("baud readback", rdData[7:0], baudVal);
    busRead(i2cPkg::AddrCtrl, i2cPkg::AccByte, rdData);
    checkByte("idle status", rdData[7:0], 8'h00);

    // Write frame, slave acks on a released line
    dataVal = i2cPkg::byteT'(nextBits(8));
    ackVal  = stepLfsr();
    issueStart(1'b1);
    runFrame({1'b0, dataVal}, {8'hFF, ackVal}, 1'b1, 1'b0);
    checkFrame("slave samples of write", slaveRx, {dataVal, ackVal});
    busRead(i2cPkg::AddrData, i2cPkg::AccWord, rdData);
    checkWord("received write frame", rdData, {7'h00, ackVal, dataVal});
    issueStop();

    // Read frame, master drives the ack
    dataVal = i2cPkg::byteT'(nextBits(8));
    ackVal  = stepLfsr();
    issueStart(1'b0);
    runFrame({ackVal, 8'h00}, {dataVal, 1'b1}, 1'b0, 1'b0);
    checkFrame("slave samples of read", slaveRx, {dataVal, ackVal});
    busRead(i2cPkg::AddrData, i2cPkg::AccWord, rdData);
    checkWord("received read frame", rdData, {7'h00, ackVal, dataVal});
    issueStop();

    // START while busy is dropped
    dataVal = i2cPkg::byteT'(nextBits(8));
    ackVal  = stepLfsr();
    issueStart(1'b1);
    runFrame({1'b0, dataVal}, {8'hFF, ackVal}, 1'b1, 1'b1);
    checkByte("start count after busy", i2cPkg::byteT'(startCount),
              i2cPkg::byteT'(expStarts));
    checkFrame("slave samples with poke", slaveRx, {dataVal, ackVal});
    busRead(i2cPkg::AddrData, i2cPkg::AccWord, rdData);
    checkWord("received frame with poke", rdData, {7'h00, ackVal, dataVal});
    issueStop();

    // Timeout
    repeat (3)
      runTimeout(nextBits(2), nextBits(2) + 16'd1);
    runTimeout(nextBits(2), 16'h0000);

    // GPIO through the synchronizer
    repeat (4)
    begin
      GpioI = GpioWidth'(nextBits(GpioWidth));
      stepClock();
      stepClock();
      busRead(i2cPkg::AddrGpio, i2cPkg::AccByte, rdData);
      checkByte("GPIO input", rdData[7:0], i2cPkg::byteT'(GpioI));
    end

    if (i_i2cMaster.i_i2cBitFsm.i_i2cBitFsmChecker.failCount == 0)
    begin
      $display("Test OK");
      $finish;
    end
    else
    begin
      $display("Sequencer assertions failed %0d times",
               i_i2cMaster.i_i2cBitFsm.i_i2cBitFsmChecker.failCount);
      abortRun();
    end
  end

endmodule

// File: i2cMaster.f
common/i2cPkg.sv
i2cBitFsm/i2cBitFsm.sv
hdl/i2cRegFile.sv
hdl/i2cTimeout.sv
hdl/i2cMaster.sv
sim/i2cBitFsm_checker.sv
sim/i2cMasterTb.sv
